// File: src/mips_pkg.sv
package mips_pkg;

	// widths fixed by the ISA
	typedef logic [31:0] data_t;
	typedef logic [31:0] instr_t;
	typedef logic [4:0]  reg_addr_t;
	typedef logic [5:0]  opcode_t;
	typedef logic [5:0]  funct_t;
	typedef logic [4:0]  shamt_t;
	typedef logic [3:0]  alu_op_t;

	// primary opcodes
	localparam opcode_t OP_RTYPE = 6'h00;
	localparam opcode_t OP_ADDI  = 6'h08;
	localparam opcode_t OP_SLTI  = 6'h0a;
	localparam opcode_t OP_ANDI  = 6'h0c;
	localparam opcode_t OP_ORI   = 6'h0d;
	localparam opcode_t OP_XORI  = 6'h0e;
	localparam opcode_t OP_LUI   = 6'h0f;
	localparam opcode_t OP_HALT  = 6'h3f;

	// funct codes of the R-type group
	localparam funct_t FN_SLL = 6'h00;
	localparam funct_t FN_SRL = 6'h02;
	localparam funct_t FN_ADD = 6'h20;
	localparam funct_t FN_SUB = 6'h22;
	localparam funct_t FN_AND = 6'h24;
	localparam funct_t FN_OR  = 6'h25;
	localparam funct_t FN_XOR = 6'h26;
	localparam funct_t FN_NOR = 6'h27;
	localparam funct_t FN_SLT = 6'h2a;

	// ALU operations, ALU_LUI is the highest defined code
	localparam alu_op_t ALU_ADD = 4'd0;
	localparam alu_op_t ALU_SUB = 4'd1;
	localparam alu_op_t ALU_AND = 4'd2;
	localparam alu_op_t ALU_OR  = 4'd3;
	localparam alu_op_t ALU_XOR = 4'd4;
	localparam alu_op_t ALU_NOR = 4'd5;
	localparam alu_op_t ALU_SLT = 4'd6;
	localparam alu_op_t ALU_SLL = 4'd7;
	localparam alu_op_t ALU_SRL = 4'd8;
	localparam alu_op_t ALU_LUI = 4'd9;

endpackage

// File: src/instr_decode.sv
`timescale 1ns/100ps

module instr_decode
(
	input  logic                clock,
	input  logic                reset,
	input  logic                en_pipeline_i,
	input  mips_pkg::instr_t    instr_i,
	input  mips_pkg::data_t     rf_rs_data_i,
	input  mips_pkg::data_t     rf_rt_data_i,
	input  logic                ex_wr_en_i,
	input  mips_pkg::reg_addr_t ex_dest_i,
	input  mips_pkg::data_t     ex_result_i,
	output mips_pkg::reg_addr_t rf_rs_o,
	output mips_pkg::reg_addr_t rf_rt_o,
	output mips_pkg::data_t     rs_data_o,
	output mips_pkg::data_t     rt_data_o,
	output mips_pkg::data_t     imm_o,
	output mips_pkg::shamt_t    shamt_o,
	output mips_pkg::reg_addr_t dest_o,
	output mips_pkg::alu_op_t   alu_op_o,
	output logic                use_imm_o,
	output logic                wr_en_o,
	output logic                halt_o
);

	mips_pkg::opcode_t opcode;
	mips_pkg::funct_t  funct;
	logic [15:0]       imm16;
	logic              valid;
	logic              is_halt;
	logic              halt_seen;

	assign opcode  = instr_i[31:26];
	assign rf_rs_o = instr_i[25:21];
	assign rf_rt_o = instr_i[20:16];
	assign shamt_o = instr_i[10:6];
	assign funct   = instr_i[5:0];
	assign imm16   = instr_i[15:0];

	always_comb
	begin
		alu_op_o  = mips_pkg::ALU_ADD;
		use_imm_o = 1'b1;
		dest_o    = instr_i[20:16];
		imm_o     = {{16{imm16[15]}}, imm16};
		valid     = 1'b1;
		is_halt   = 1'b0;
		case (opcode)
			mips_pkg::OP_RTYPE:
			begin
				use_imm_o = 1'b0;
				dest_o    = instr_i[15:11];
				case (funct)
					mips_pkg::FN_ADD: alu_op_o = mips_pkg::ALU_ADD;
					mips_pkg::FN_SUB: alu_op_o = mips_pkg::ALU_SUB;
					mips_pkg::FN_AND: alu_op_o = mips_pkg::ALU_AND;
					mips_pkg::FN_OR:  alu_op_o = mips_pkg::ALU_OR;
					mips_pkg::FN_XOR: alu_op_o = mips_pkg::ALU_XOR;
					mips_pkg::FN_NOR: alu_op_o = mips_pkg::ALU_NOR;
					mips_pkg::FN_SLT: alu_op_o = mips_pkg::ALU_SLT;
					mips_pkg::FN_SLL: alu_op_o = mips_pkg::ALU_SLL;
					mips_pkg::FN_SRL: alu_op_o = mips_pkg::ALU_SRL;
					default:          valid    = 1'b0;
				endcase
			end
			mips_pkg::OP_ADDI: alu_op_o = mips_pkg::ALU_ADD;
			mips_pkg::OP_SLTI: alu_op_o = mips_pkg::ALU_SLT;
			// logical immediates are zero-extended
			mips_pkg::OP_ANDI:
			begin
				alu_op_o = mips_pkg::ALU_AND;
				imm_o    = {16'b0, imm16};
			end
			mips_pkg::OP_ORI:
			begin
				alu_op_o = mips_pkg::ALU_OR;
				imm_o    = {16'b0, imm16};
			end
			mips_pkg::OP_XORI:
			begin
				alu_op_o = mips_pkg::ALU_XOR;
				imm_o    = {16'b0, imm16};
			end
			mips_pkg::OP_LUI:
			begin
				alu_op_o = mips_pkg::ALU_LUI;
				imm_o    = {imm16, 16'b0};
			end
			mips_pkg::OP_HALT: is_halt = 1'b1;
			default:           valid   = 1'b0;
		endcase
	end

	// halt itself travels on, everything after it is a bubble
	assign wr_en_o = valid && !is_halt && !halt_seen;
	assign halt_o  = valid && is_halt && !halt_seen;

	// younger result still in execute wins over the register file
	assign rs_data_o = (ex_wr_en_i && ex_dest_i != '0 && ex_dest_i == rf_rs_o) ?
		ex_result_i : rf_rs_data_i;
	assign rt_data_o = (ex_wr_en_i && ex_dest_i != '0 && ex_dest_i == rf_rt_o) ?
		ex_result_i : rf_rt_data_i;

	always_ff @(posedge clock)
	begin
		if (reset)
			halt_seen <= 1'b0;
		else if (en_pipeline_i && halt_o)
			halt_seen <= 1'b1;
	end

endmodule

// File: src/register_file.sv
`timescale 1ns/100ps

module register_file
(
	input  logic                clock,
	input  logic                reset,
	input  logic                wr_en_i,
	input  mips_pkg::reg_addr_t wr_addr_i,
	input  mips_pkg::data_t     wr_data_i,
	input  mips_pkg::reg_addr_t rs_addr_i,
	input  mips_pkg::reg_addr_t rt_addr_i,
	output mips_pkg::data_t     rs_data_o,
	output mips_pkg::data_t     rt_data_o
);

	mips_pkg::data_t regs [32];

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end
		else if (wr_en_i && wr_addr_i != '0)
			regs[wr_addr_i] <= wr_data_i;
	end

	// a write in flight is seen by a read of the same register
	function automatic mips_pkg::data_t read_port(input mips_pkg::reg_addr_t addr);
		if (addr == '0)
			return '0;
		else if (wr_en_i && wr_addr_i == addr)
			return wr_data_i;
		else
			return regs[addr];
	endfunction

	assign rs_data_o = read_port(rs_addr_i);
	assign rt_data_o = read_port(rt_addr_i);

	// writeback drops register 0 before it reaches this port
	a_no_reg0_write: assert property (@(posedge clock) disable iff (reset)
		wr_en_i |-> (wr_addr_i != '0))
		else $error("register_file: write request to register 0");

endmodule

// File: src/decode_execute_stage.sv
`timescale 1ns/100ps

module decode_execute_stage
(
	input  logic                clock,
	input  logic                reset,
	input  logic                en_pipeline_i,
	input  mips_pkg::reg_addr_t rs_i,
	input  mips_pkg::reg_addr_t rt_i,
	input  mips_pkg::data_t     rs_data_i,
	input  mips_pkg::data_t     rt_data_i,
	input  mips_pkg::data_t     imm_i,
	input  mips_pkg::shamt_t    shamt_i,
	input  mips_pkg::reg_addr_t dest_i,
	input  mips_pkg::alu_op_t   alu_op_i,
	input  logic                use_imm_i,
	input  logic                wr_en_i,
	input  logic                halt_i,
	output mips_pkg::reg_addr_t rs_o,
	output mips_pkg::reg_addr_t rt_o,
	output mips_pkg::data_t     rs_data_o,
	output mips_pkg::data_t     rt_data_o,
	output mips_pkg::data_t     imm_o,
	output mips_pkg::shamt_t    shamt_o,
	output mips_pkg::reg_addr_t dest_o,
	output mips_pkg::alu_op_t   alu_op_o,
	output logic                use_imm_o,
	output logic                wr_en_o,
	output logic                halt_o
);

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			// bubble
			rs_o      <= '0;
			rt_o      <= '0;
			rs_data_o <= '0;
			rt_data_o <= '0;
			imm_o     <= '0;
			shamt_o   <= '0;
			dest_o    <= '0;
			alu_op_o  <= mips_pkg::ALU_ADD;
			use_imm_o <= 1'b0;
			wr_en_o   <= 1'b0;
			halt_o    <= 1'b0;
		end
		else if (en_pipeline_i)
		begin
			rs_o      <= rs_i;
			rt_o      <= rt_i;
			rs_data_o <= rs_data_i;
			rt_data_o <= rt_data_i;
			imm_o     <= imm_i;
			shamt_o   <= shamt_i;
			dest_o    <= dest_i;
			alu_op_o  <= alu_op_i;
			use_imm_o <= use_imm_i;
			wr_en_o   <= wr_en_i;
			halt_o    <= halt_i;
		end
	end

	// a halt slot never carries a register write
	a_halt_no_write: assert property (@(posedge clock) disable iff (reset)
		halt_o |-> !wr_en_o)
		else $error("decode_execute_stage: halt slot also writes a register");

	// register 0 arrives as zero through both the register file and the bypass
	a_zero_operand: assert property (@(posedge clock) disable iff (reset)
		((rs_o != '0) || (rs_data_o == '0)) && ((rt_o != '0) || (rt_data_o == '0)))
		else $error("decode_execute_stage: nonzero data for register 0");

endmodule

// File: src/alu_execute.sv
`timescale 1ns/100ps

module alu_execute
(
	input  mips_pkg::data_t   rs_data_i,
	input  mips_pkg::data_t   rt_data_i,
	input  mips_pkg::data_t   imm_i,
	input  mips_pkg::shamt_t  shamt_i,
	input  mips_pkg::alu_op_t alu_op_i,
	input  logic              use_imm_i,
	output mips_pkg::data_t   result_o
);

	mips_pkg::data_t op_b;

	assign op_b = use_imm_i ? imm_i : rt_data_i;

	always_comb
	begin
		case (alu_op_i)
			mips_pkg::ALU_ADD:
				result_o = rs_data_i + op_b;
			mips_pkg::ALU_SUB:
				result_o = rs_data_i - op_b;
			mips_pkg::ALU_AND:
				result_o = rs_data_i & op_b;
			mips_pkg::ALU_OR:
				result_o = rs_data_i | op_b;
			mips_pkg::ALU_XOR:
				result_o = rs_data_i ^ op_b;
			mips_pkg::ALU_NOR:
				result_o = ~(rs_data_i | op_b);
			// signed compare, also used by slti
			mips_pkg::ALU_SLT:
				result_o = mips_pkg::data_t'($signed(rs_data_i) < $signed(op_b));
			mips_pkg::ALU_SLL:
				result_o = rt_data_i << shamt_i;
			mips_pkg::ALU_SRL:
				result_o = rt_data_i >> shamt_i;
			// immediate already sits in the upper half
			mips_pkg::ALU_LUI:
				result_o = op_b;
			default:
				result_o = '0;
		endcase
	end

	always_comb
	begin
		if (!$isunknown(alu_op_i))
		begin
			a_alu_op_defined: assert (alu_op_i <= mips_pkg::ALU_LUI)
				else $error("alu_execute: undefined alu_op %0d", alu_op_i);
		end
	end

endmodule

// File: src/execute_writeback_stage.sv
`timescale 1ns/100ps

module execute_writeback_stage
(
	input  logic                clock,
	input  logic                reset,
	input  logic                en_pipeline_i,
	input  logic                wr_en_i,
	input  mips_pkg::reg_addr_t dest_i,
	input  mips_pkg::data_t     result_i,
	input  logic                halt_i,
	output logic                wb_en_o,
	output mips_pkg::reg_addr_t wb_reg_o,
	output mips_pkg::data_t     wb_data_o,
	output logic                rf_wr_en_o,
	output logic                halt_o
);

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			wb_en_o   <= 1'b0;
			wb_reg_o  <= '0;
			wb_data_o <= '0;
			halt_o    <= 1'b0;
		end
		else if (en_pipeline_i)
		begin
			// writes to register 0 vanish here
			wb_en_o   <= wr_en_i && (dest_i != '0);
			wb_reg_o  <= dest_i;
			wb_data_o <= result_i;
			if (halt_i)
				halt_o <= 1'b1;
		end
	end

	// the held write is not repeated while the pipeline is frozen
	assign rf_wr_en_o = wb_en_o && en_pipeline_i;

	// decode has squashed everything behind the halt
	a_no_write_after_halt: assert property (@(posedge clock) disable iff (reset)
		halt_o |-> !wr_en_i)
		else $error("execute_writeback_stage: write behind halt");

endmodule

// File: src/mips_core_top.sv
`timescale 1ns/100ps

module mips_core_top
(
	input  logic                clock,
	input  logic                reset,
	input  logic                en_pipeline_i,
	input  mips_pkg::instr_t    instr_i,
	output logic                wb_en_o,
	output mips_pkg::reg_addr_t wb_reg_o,
	output mips_pkg::data_t     wb_data_o,
	output logic                halt_o
);

	// decode side
	mips_pkg::reg_addr_t id_rs;
	mips_pkg::reg_addr_t id_rt;
	mips_pkg::data_t     rf_rs_data;
	mips_pkg::data_t     rf_rt_data;
	mips_pkg::data_t     id_rs_data;
	mips_pkg::data_t     id_rt_data;
	mips_pkg::data_t     id_imm;
	mips_pkg::shamt_t    id_shamt;
	mips_pkg::reg_addr_t id_dest;
	mips_pkg::alu_op_t   id_alu_op;
	logic                id_use_imm;
	logic                id_wr_en;
	logic                id_halt;

	// execute side
	mips_pkg::reg_addr_t ex_rs;
	mips_pkg::reg_addr_t ex_rt;
	mips_pkg::data_t     ex_rs_data;
	mips_pkg::data_t     ex_rt_data;
	mips_pkg::data_t     ex_imm;
	mips_pkg::shamt_t    ex_shamt;
	mips_pkg::reg_addr_t ex_dest;
	mips_pkg::alu_op_t   ex_alu_op;
	logic                ex_use_imm;
	logic                ex_wr_en;
	logic                ex_halt;
	mips_pkg::data_t     ex_result;

	logic                rf_wr_en;

	instr_decode u_decode
	(
		.clock         (clock),
		.reset         (reset),
		.en_pipeline_i (en_pipeline_i),
		.instr_i       (instr_i),
		.rf_rs_data_i  (rf_rs_data),
		.rf_rt_data_i  (rf_rt_data),
		.ex_wr_en_i    (ex_wr_en),
		.ex_dest_i     (ex_dest),
		.ex_result_i   (ex_result),
		.rf_rs_o       (id_rs),
		.rf_rt_o       (id_rt),
		.rs_data_o     (id_rs_data),
		.rt_data_o     (id_rt_data),
		.imm_o         (id_imm),
		.shamt_o       (id_shamt),
		.dest_o        (id_dest),
		.alu_op_o      (id_alu_op),
		.use_imm_o     (id_use_imm),
		.wr_en_o       (id_wr_en),
		.halt_o        (id_halt)
	);

	register_file u_regfile
	(
		.clock     (clock),
		.reset     (reset),
		.wr_en_i   (rf_wr_en),
		.wr_addr_i (wb_reg_o),
		.wr_data_i (wb_data_o),
		.rs_addr_i (id_rs),
		.rt_addr_i (id_rt),
		.rs_data_o (rf_rs_data),
		.rt_data_o (rf_rt_data)
	);

	decode_execute_stage u_id_ex
	(
		.clock         (clock),
		.reset         (reset),
		.en_pipeline_i (en_pipeline_i),
		.rs_i          (id_rs),
		.rt_i          (id_rt),
		.rs_data_i     (id_rs_data),
		.rt_data_i     (id_rt_data),
		.imm_i         (id_imm),
		.shamt_i       (id_shamt),
		.dest_i        (id_dest),
		.alu_op_i      (id_alu_op),
		.use_imm_i     (id_use_imm),
		.wr_en_i       (id_wr_en),
		.halt_i        (id_halt),
		.rs_o          (ex_rs),
		.rt_o          (ex_rt),
		.rs_data_o     (ex_rs_data),
		.rt_data_o     (ex_rt_data),
		.imm_o         (ex_imm),
		.shamt_o       (ex_shamt),
		.dest_o        (ex_dest),
		.alu_op_o      (ex_alu_op),
		.use_imm_o     (ex_use_imm),
		.wr_en_o       (ex_wr_en),
		.halt_o        (ex_halt)
	);

	alu_execute u_alu
	(
		.rs_data_i (ex_rs_data),
		.rt_data_i (ex_rt_data),
		.imm_i     (ex_imm),
		.shamt_i   (ex_shamt),
		.alu_op_i  (ex_alu_op),
		.use_imm_i (ex_use_imm),
		.result_o  (ex_result)
	);

	execute_writeback_stage u_ex_wb
	(
		.clock         (clock),
		.reset         (reset),
		.en_pipeline_i (en_pipeline_i),
		.wr_en_i       (ex_wr_en),
		.dest_i        (ex_dest),
		.result_i      (ex_result),
		.halt_i        (ex_halt),
		.wb_en_o       (wb_en_o),
		.wb_reg_o      (wb_reg_o),
		.wb_data_o     (wb_data_o),
		.rf_wr_en_o    (rf_wr_en),
		.halt_o        (halt_o)
	);

endmodule

// File: bench/mips_ref_model.svh
`ifndef MIPS_REF_MODEL_SVH
`define MIPS_REF_MODEL_SVH

// architectural state, one instruction at a time in program order
mips_pkg::data_t     model_regs [32];
logic                model_halted;
mips_pkg::reg_addr_t exp_reg[$];
mips_pkg::data_t     exp_data[$];

task automatic model_reset();
	for (int r = 0; r < 32; r++)
		model_regs[r] = '0;
	model_halted = 1'b0;
	exp_reg.delete();
	exp_data.delete();
endtask

function automatic mips_pkg::instr_t encode_r(input mips_pkg::funct_t fn,
	input mips_pkg::reg_addr_t rs, input mips_pkg::reg_addr_t rt,
	input mips_pkg::reg_addr_t rd, input mips_pkg::shamt_t sh);
	return {mips_pkg::OP_RTYPE, rs, rt, rd, sh, fn};
endfunction

function automatic mips_pkg::instr_t encode_i(input mips_pkg::opcode_t op,
	input mips_pkg::reg_addr_t rs, input mips_pkg::reg_addr_t rt, input logic [15:0] imm);
	return {op, rs, rt, imm};
endfunction

task automatic run_model(input mips_pkg::instr_t instr);
	mips_pkg::opcode_t   op;
	mips_pkg::funct_t    fn;
	mips_pkg::reg_addr_t rs;
	mips_pkg::reg_addr_t rt;
	mips_pkg::reg_addr_t dest;
	mips_pkg::shamt_t    sh;
	logic [15:0]         imm;
	mips_pkg::data_t     a;
	mips_pkg::data_t     b;
	mips_pkg::data_t     sext;
	mips_pkg::data_t     zext;
	mips_pkg::data_t     value;
	logic                writes;
	op     = instr[31:26];
	rs     = instr[25:21];
	rt     = instr[20:16];
	dest   = instr[15:11];
	sh     = instr[10:6];
	fn     = instr[5:0];
	imm    = instr[15:0];
	a      = model_regs[rs];
	b      = model_regs[rt];
	sext   = {{16{imm[15]}}, imm};
	zext   = {16'b0, imm};
	value  = '0;
	writes = 1'b1;
	// everything behind a halt is dropped
	if (model_halted)
		return;
	case (op)
		mips_pkg::OP_RTYPE:
		begin
			case (fn)
				mips_pkg::FN_ADD: value = a + b;
				mips_pkg::FN_SUB: value = a - b;
				mips_pkg::FN_AND: value = a & b;
				mips_pkg::FN_OR:  value = a | b;
				mips_pkg::FN_XOR: value = a ^ b;
				mips_pkg::FN_NOR: value = ~(a | b);
				mips_pkg::FN_SLT: value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
				mips_pkg::FN_SLL: value = b << sh;
				mips_pkg::FN_SRL: value = b >> sh;
				default:          writes = 1'b0;
			endcase
		end
		mips_pkg::OP_ADDI:
		begin
			dest  = rt;
			value = a + sext;
		end
		mips_pkg::OP_SLTI:
		begin
			dest  = rt;
			value = ($signed(a) < $signed(sext)) ? 32'd1 : 32'd0;
		end
		mips_pkg::OP_ANDI:
		begin
			dest  = rt;
			value = a & zext;
		end
		mips_pkg::OP_ORI:
		begin
			dest  = rt;
			value = a | zext;
		end
		mips_pkg::OP_XORI:
		begin
			dest  = rt;
			value = a ^ zext;
		end
		mips_pkg::OP_LUI:
		begin
			dest  = rt;
			value = {imm, 16'b0};
		end
		mips_pkg::OP_HALT:
		begin
			model_halted = 1'b1;
			writes       = 1'b0;
		end
		default: writes = 1'b0;
	endcase
	if (writes && dest != '0)
	begin
		model_regs[dest] = value;
		exp_reg.push_back(dest);
		exp_data.push_back(value);
	end
endtask

`endif

// File: bench/mips_core_tb.sv
`timescale 1ns/100ps

module mips_core_tb;

	localparam int PROGRAM_LEN    = 400;
	localparam int TAIL_LEN       = 8;
	localparam int TIMEOUT_CYCLES = PROGRAM_LEN * 2 + 200;

	logic                clock;
	logic                reset;
	logic                en_pipeline_i;
	mips_pkg::instr_t    instr_i;
	logic                wb_en_o;
	mips_pkg::reg_addr_t wb_reg_o;
	mips_pkg::data_t     wb_data_o;
	logic                halt_o;

	int               cycle_count = 0;
	int               value_errors = 0;
	int               other_errors = 0;
	int               writes_checked = 0;
	logic             halt_was_high = 1'b0;
	mips_pkg::instr_t program_q[$];

	`include "mips_ref_model.svh"

	mips_core_top dut_i
	(
		.clock         (clock),
		.reset         (reset),
		.en_pipeline_i (en_pipeline_i),
		.instr_i       (instr_i),
		.wb_en_o       (wb_en_o),
		.wb_reg_o      (wb_reg_o),
		.wb_data_o     (wb_data_o),
		.halt_o        (halt_o)
	);

	always #20 clock = ~clock;

	always @(posedge clock)
		cycle_count <= cycle_count + 1;

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected)
		begin
			value_errors++;
			$display("FAIL t=%0t %s: got %h, expected %h", $time, name, actual, expected);
		end
	endtask

	task automatic report_problem(input string text);
		other_errors++;
		$display("ERROR t=%0t %s", $time, text);
	endtask

	task automatic report_counts();
		$display("errors: %0d value mismatches, %0d other errors, %0d writebacks checked",
			value_errors, other_errors, writes_checked);
	endtask

	// low registers most of the time so results are reused soon
	function automatic mips_pkg::reg_addr_t pick_reg();
		if ($urandom_range(3) != 0)
			return mips_pkg::reg_addr_t'($urandom_range(7));
		else
			return mips_pkg::reg_addr_t'($urandom_range(31));
	endfunction

	function automatic mips_pkg::instr_t random_instr();
		int                  kind;
		mips_pkg::reg_addr_t rs;
		mips_pkg::reg_addr_t rt;
		mips_pkg::reg_addr_t rd;
		mips_pkg::shamt_t    sh;
		logic [15:0]         imm;
		mips_pkg::instr_t    word;
		kind = $urandom_range(14);
		rs   = pick_reg();
		rt   = pick_reg();
		rd   = pick_reg();
		sh   = mips_pkg::shamt_t'($urandom_range(31));
		imm  = 16'($urandom);
		case (kind)
			0:  word = encode_r(mips_pkg::FN_ADD, rs, rt, rd, '0);
			1:  word = encode_r(mips_pkg::FN_SUB, rs, rt, rd, '0);
			2:  word = encode_r(mips_pkg::FN_AND, rs, rt, rd, '0);
			3:  word = encode_r(mips_pkg::FN_OR, rs, rt, rd, '0);
			4:  word = encode_r(mips_pkg::FN_XOR, rs, rt, rd, '0);
			5:  word = encode_r(mips_pkg::FN_NOR, rs, rt, rd, '0);
			6:  word = encode_r(mips_pkg::FN_SLT, rs, rt, rd, '0);
			7:  word = encode_r(mips_pkg::FN_SLL, '0, rt, rd, sh);
			8:  word = encode_r(mips_pkg::FN_SRL, '0, rt, rd, sh);
			9:  word = encode_i(mips_pkg::OP_ADDI, rs, rt, imm);
			10: word = encode_i(mips_pkg::OP_SLTI, rs, rt, imm);
			11: word = encode_i(mips_pkg::OP_ANDI, rs, rt, imm);
			12: word = encode_i(mips_pkg::OP_ORI, rs, rt, imm);
			13: word = encode_i(mips_pkg::OP_XORI, rs, rt, imm);
			default: word = encode_i(mips_pkg::OP_LUI, '0, rt, imm);
		endcase
		return word;
	endfunction

	// stalls put junk on instr_i, which the core must ignore
	task automatic issue_instr(input mips_pkg::instr_t instr);
		logic stall;
		do
		begin
			@(posedge clock);
			#2;
			stall = ($urandom_range(3) == 0);
			en_pipeline_i = !stall;
			if (stall)
				instr_i = $urandom;
		end
		while (stall);
		instr_i = instr;
		run_model(instr);
	endtask

	// a write lands in the register file at the coming edge if enable is high
	always @(negedge clock)
	begin
		if (!reset)
		begin
			if (halt_o && !model_halted)
				report_problem("halt_o is high before the halt was issued");
			if (halt_was_high && !halt_o)
				report_problem("halt_o dropped after it had risen");
			halt_was_high = halt_o;
			if (wb_en_o && en_pipeline_i)
			begin
				if (exp_reg.size() == 0)
					report_problem($sformatf("unexpected write of %h to register %0d",
						wb_data_o, wb_reg_o));
				else
				begin
					check_value("wb_reg_o", 32'(wb_reg_o), 32'(exp_reg.pop_front()));
					check_value("wb_data_o", wb_data_o, exp_data.pop_front());
					writes_checked++;
				end
			end
		end
	end

	initial
	begin
		wait (cycle_count >= TIMEOUT_CYCLES);
		report_problem($sformatf("timeout, run did not finish within %0d cycles",
			TIMEOUT_CYCLES));
		report_counts();
		$display("Result: FAILED");
		$finish;
	end

	initial
	begin
		void'($urandom(32'he1a9));
		clock         = 1'b0;
		reset         = 1'b1;
		en_pipeline_i = 1'b0;
		instr_i       = '0;
		model_reset();
		for (int i = 0; i < PROGRAM_LEN; i++)
			program_q.push_back(random_instr());
		program_q.push_back({mips_pkg::OP_HALT, 26'b0});
		for (int i = 0; i < TAIL_LEN; i++)
			program_q.push_back(random_instr());

		repeat (10) @(posedge clock);
		#2;
		reset = 1'b0;
		check_value("wb_en_o", 32'(wb_en_o), 32'd0);
		check_value("halt_o", 32'(halt_o), 32'd0);

		foreach (program_q[i])
			issue_instr(program_q[i]);
		// keep feeding until the halt reaches writeback
		while (!halt_o)
			issue_instr(random_instr());
		repeat (6) issue_instr(random_instr());
		@(posedge clock);
		#2;
		en_pipeline_i = 1'b0;
		repeat (2) @(negedge clock);
		#1;

		if (exp_reg.size() != 0)
			report_problem($sformatf("%0d expected writebacks never appeared", exp_reg.size()));
		check_value("halt_o", 32'(halt_o), 32'd1);
		report_counts();
		if (value_errors + other_errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

// File: mips_core.f
+incdir+bench
src/mips_pkg.sv
src/instr_decode.sv
src/register_file.sv
src/decode_execute_stage.sv
src/alu_execute.sv
src/execute_writeback_stage.sv
src/mips_core_top.sv
bench/mips_core_tb.sv

// File: build.sh
#!/usr/bin/env bash
# compile the core and its testbench with Verilator, run it, judge the log

set -u
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module mips_core_tb \
	-f mips_core.f \
	--Mdir obj_dir -o mips_core_sim
if [ $? -ne 0 ]; then
	echo "build: Verilator compile failed"
	exit 1
fi

./obj_dir/mips_core_sim > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
	echo "build: simulation exited with status $run_status"
	exit 1
fi

if grep -q "^Result: PASSED$" sim.log; then
	exit 0
fi
exit 1
